//--- rtl/fpm_pkg.sv
// fpm package
// widths, operation and state encodings, and the packed structs shared by
// the mantissa alignment/normalization unit and its testbench

`default_nettype none

package fpm_pkg;

	// mantissa register is built from byte slices
	localparam int NSLICE = 5;

	typedef logic signed [7:0] exp_t;

	// two's-complement fraction, top bit is the sign
	typedef logic [NSLICE*8-1:0] mant_t;

	typedef logic [7:0] byte_t;

	// shift count, 0 to 40
	typedef logic [5:0] cnt_t;

	typedef enum logic {
		FOP_NORM,
		FOP_ALIGN
	} fop_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_SHIFT,
		S_DONE
	} seq_state_t;

	// broadcast to every slice, valid for one cycle
	typedef struct packed {
		logic load;
		logic shl;
		logic shr;
		logic fill;
	} slice_ctl_t;

	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} fpm_flags_t;

endpackage

`default_nettype wire

//--- rtl/fpm_slice.sv
// fpm mantissa slice
// one byte of the mantissa register; loads, or shifts one place left or
// right taking the neighbor bit at the open end

`timescale 1ns/1ps
`default_nettype none

module fpm_slice (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire fpm_pkg::slice_ctl_t ctl,
	input wire fpm_pkg::byte_t load_byte,
	input wire logic lo_in,
	input wire logic hi_in,
	output fpm_pkg::byte_t q
);

	import fpm_pkg::*;

	byte_t q_nx;

	// load wins over the shifts
	always_comb begin
		q_nx = q;
		if (ctl.load) begin
			q_nx = load_byte;
		end else if (ctl.shl) begin
			q_nx = {q[6:0], lo_in};
		end else if (ctl.shr) begin
			q_nx = {hi_in, q[7:1]};
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			q <= '0;
		end else begin
			q <= q_nx;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fpm_seq.sv
// fpm sequencer
// exponent register, difference adder with saturating shift counter and the
// control FSM that steps the mantissa slices through a normalize or an align

`timescale 1ns/1ps
`default_nettype none

module fpm_seq (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire logic start,
	input wire fpm_pkg::fop_t op,
	input wire fpm_pkg::exp_t exp_in,
	input wire fpm_pkg::exp_t exp_ref,
	input wire logic sign_in,
	input wire logic norm_stop,
	input wire logic mant_zero,
	output fpm_pkg::slice_ctl_t slice_ctl,
	output fpm_pkg::exp_t exp_out,
	output logic busy,
	output logic done,
	output logic range_err
);

	import fpm_pkg::*;

	// full mantissa width, anything beyond shifts out only sign bits
	localparam cnt_t MAX_SHIFT = cnt_t'($bits(mant_t));
	localparam exp_t EXP_MIN = exp_t'(8'h80);

	seq_state_t state;
	seq_state_t state_nx;
	fop_t op_q;
	logic sign_q;
	cnt_t cnt;
	cnt_t cnt_ld;
	exp_t exp_q;
	logic signed [8:0] diff;

	logic accept;
	logic in_norm;
	logic in_align;
	logic at_floor;
	logic shift_l;
	logic shift_r;
	logic underflow;
	logic zero_stop;
	logic finish;

	// exp_ref - exp_in, one bit wider so it cannot wrap
	assign diff = $signed({exp_ref[7], exp_ref}) - $signed({exp_in[7], exp_in});

	always_comb begin
		if (diff[8]) begin
			cnt_ld = '0;
		end else if (diff > $signed({3'b000, MAX_SHIFT})) begin
			cnt_ld = MAX_SHIFT;
		end else begin
			cnt_ld = cnt_t'(diff[5:0]);
		end
	end

	assign accept = (state == S_IDLE) && start;
	assign in_norm = (state == S_SHIFT) && (op_q == FOP_NORM);
	assign in_align = (state == S_SHIFT) && (op_q == FOP_ALIGN);

	// exponent cannot take another decrement
	assign at_floor = (exp_q == EXP_MIN);

	assign shift_l = in_norm && !norm_stop && !at_floor;
	assign underflow = in_norm && !norm_stop && at_floor;
	assign zero_stop = in_norm && norm_stop && mant_zero;
	assign shift_r = in_align && (cnt != '0);

	assign finish = (in_norm && (norm_stop || at_floor)) || (in_align && (cnt == '0));

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_nx = S_SHIFT;
				end
			end
			S_SHIFT: begin
				if (finish) begin
					state_nx = S_DONE;
				end
			end
			default: begin
				state_nx = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			state <= S_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	// operation and sign are held for the whole operation
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			op_q <= FOP_NORM;
			sign_q <= 1'b0;
		end else if (accept) begin
			op_q <= op;
			sign_q <= sign_in;
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			cnt <= '0;
		end else if (accept) begin
			cnt <= cnt_ld;
		end else if (shift_r) begin
			cnt <= cnt - cnt_t'(1);
		end
	end

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			exp_q <= '0;
		end else if (accept) begin
			exp_q <= (op == FOP_NORM) ? exp_in : exp_ref;
		end else if (underflow || zero_stop) begin
			exp_q <= '0;
		end else if (shift_l) begin
			exp_q <= exp_q - exp_t'(1);
		end
	end

	// negative align difference or normalize underflow
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			range_err <= 1'b0;
		end else if (accept) begin
			range_err <= (op == FOP_ALIGN) && diff[8];
		end else if (underflow) begin
			range_err <= 1'b1;
		end
	end

	// underflow reloads the slices, the top feeds zero bytes while busy
	assign slice_ctl = '{
		load: accept || underflow,
		shl: shift_l,
		shr: shift_r,
		fill: shift_r && sign_q
	};

	assign exp_out = exp_q;
	assign busy = (state != S_IDLE);
	assign done = (state == S_DONE);

endmodule

`default_nettype wire

//--- rtl/fpm_collect.sv
// fpm result collector
// joins the slice bytes into the mantissa, reports normalization status,
// keeps the align sticky bit and captures the flags at completion

`timescale 1ns/1ps
`default_nettype none

module fpm_collect #(
	parameter int n_slice = fpm_pkg::NSLICE
) (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire fpm_pkg::byte_t [n_slice-1:0] slice_q,
	input wire fpm_pkg::slice_ctl_t slice_ctl,
	input wire logic done,
	input wire logic range_err,
	output fpm_pkg::mant_t mant_out,
	output logic norm_stop,
	output logic mant_zero,
	output fpm_pkg::fpm_flags_t flags
);

	import fpm_pkg::*;

	localparam int MSB = $bits(mant_t) - 1;

	logic sticky;
	fpm_flags_t flags_now;
	fpm_flags_t flags_q;

	// slice 0 is the low byte
	assign mant_out = slice_q;

	assign mant_zero = (mant_out == '0);

	// normalized once sign and next bit differ
	assign norm_stop = mant_zero || (mant_out[MSB] != mant_out[MSB-1]);

	// bit 0 of the bottom slice falls off on every right shift
	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			sticky <= 1'b0;
		end else if (slice_ctl.load) begin
			sticky <= 1'b0;
		end else if (slice_ctl.shr) begin
			sticky <= sticky | slice_q[0][0];
		end
	end

	assign flags_now = '{
		z: mant_zero,
		m: mant_out[MSB],
		v: range_err,
		c: sticky
	};

	always_ff @(posedge f2strob or negedge M55_6) begin
		if (!M55_6) begin
			flags_q <= '0;
		end else if (done) begin
			flags_q <= flags_now;
		end
	end

	// live during the done cycle, held copy afterwards
	assign flags = done ? flags_now : flags_q;

endmodule

`default_nettype wire

//--- rtl/fpm_top.sv
// fpm top level
// floating-point mantissa alignment and normalization unit: sequencer,
// byte-sliced mantissa register and result collector

`timescale 1ns/1ps
`default_nettype none

module fpm_top #(
	parameter int n_slice = fpm_pkg::NSLICE
) (
	input wire logic f2strob,
	input wire logic M55_6,
	input wire logic start,
	input wire fpm_pkg::fop_t op,
	input wire fpm_pkg::exp_t exp_in,
	input wire fpm_pkg::exp_t exp_ref,
	input wire fpm_pkg::mant_t mant_in,
	output logic busy,
	output logic done,
	output fpm_pkg::exp_t exp_out,
	output fpm_pkg::mant_t mant_out,
	output fpm_pkg::fpm_flags_t flags
);

	import fpm_pkg::*;

	slice_ctl_t slice_ctl;
	byte_t [n_slice-1:0] slice_q;
	logic norm_stop;
	logic mant_zero;
	logic range_err;

	fpm_seq i_fpm_seq (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.start(start),
		.op(op),
		.exp_in(exp_in),
		.exp_ref(exp_ref),
		.sign_in(mant_in[$bits(mant_t)-1]),
		.norm_stop(norm_stop),
		.mant_zero(mant_zero),
		.slice_ctl(slice_ctl),
		.exp_out(exp_out),
		.busy(busy),
		.done(done),
		.range_err(range_err)
	);

	generate
		for (genvar i = 0; i < n_slice; i++) begin : g_slice
			byte_t load_byte;
			logic lo_in;
			logic hi_in;

			// zero bytes for the reload after an underflow
			assign load_byte = busy ? '0 : mant_in[i*8 +: 8];

			if (i == 0) begin : g_lo_end
				assign lo_in = slice_ctl.fill;
			end else begin : g_lo_chain
				assign lo_in = slice_q[i-1][7];
			end

			if (i == n_slice - 1) begin : g_hi_end
				assign hi_in = slice_ctl.fill;
			end else begin : g_hi_chain
				assign hi_in = slice_q[i+1][0];
			end

			fpm_slice i_fpm_slice (
				.f2strob(f2strob),
				.M55_6(M55_6),
				.ctl(slice_ctl),
				.load_byte(load_byte),
				.lo_in(lo_in),
				.hi_in(hi_in),
				.q(slice_q[i])
			);
		end
	endgenerate

	fpm_collect #(
		.n_slice(n_slice)
	) i_fpm_collect (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.slice_q(slice_q),
		.slice_ctl(slice_ctl),
		.done(done),
		.range_err(range_err),
		.mant_out(mant_out),
		.norm_stop(norm_stop),
		.mant_zero(mant_zero),
		.flags(flags)
	);

endmodule

`default_nettype wire

//--- verification/fpm_tb_tasks.svh
// fpm testbench helpers
// LFSR operand source, operation drive and wait, reference model
// and the typed compare tasks

`ifndef FPM_TB_TASKS_SVH
`define FPM_TB_TASKS_SVH

	// Galois form, shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
	endfunction

	function automatic mant_t take_bits(input int n);
		mant_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[MSB-1:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic pulse_start(input fop_t o, input exp_t ei, input exp_t er, input mant_t mi);
		@(posedge f2strob);
		#2;
		start = 1'b1;
		op = o;
		exp_in = ei;
		exp_ref = er;
		mant_in = mi;
		@(posedge f2strob);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_for_done();
		int waited;
		waited = 0;
		@(negedge f2strob);
		while (!done && waited < DONE_WAIT) begin
			@(negedge f2strob);
			waited++;
		end
		if (!done) begin
			errors++;
			$display("done did not arrive within %0d cycles at %0t", DONE_WAIT, $time);
		end
	endtask

	// expected results worked out bit by bit from the operation rules
	task automatic ref_model(input fop_t o, input exp_t ei, input exp_t er, input mant_t mi,
			output exp_t e_want, output mant_t m_want, output fpm_flags_t f_want);
		mant_t m;
		exp_t e;
		int diff;
		int n;
		logic lost;
		logic range;
		m = mi;
		lost = 1'b0;
		range = 1'b0;
		if (o == FOP_NORM) begin
			e = ei;
			while (m != '0 && m[MSB] == m[MSB-1] && !range) begin
				if (e == EXP_FLOOR) begin
					range = 1'b1;
				end else begin
					m = m << 1;
					e = e - 8'sd1;
				end
			end
			if (range || m == '0) begin
				m = '0;
				e = 8'sd0;
			end
		end else begin
			e = er;
			diff = int'(er) - int'(ei);
			if (diff < 0) begin
				range = 1'b1;
			end else begin
				n = (diff > 40) ? 40 : diff;
				for (int i = 0; i < n; i++) begin
					lost = lost | m[0];
					m = {m[MSB], m[MSB:1]};
				end
			end
		end
		e_want = e;
		m_want = m;
		f_want.z = (m == '0);
		f_want.m = m[MSB];
		f_want.v = range;
		f_want.c = lost;
	endtask

	task automatic check_exp(input string name, input exp_t got, input exp_t want);
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_mant(input string name, input mant_t got, input mant_t want);
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_flags(input string name, input fpm_flags_t got, input fpm_flags_t want);
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s zmvc got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_result(input fop_t o, input exp_t ei, input exp_t er, input mant_t mi);
		exp_t e_want;
		mant_t m_want;
		fpm_flags_t f_want;
		ref_model(o, ei, er, mi, e_want, m_want, f_want);
		check_exp("exp_out", exp_out, e_want);
		check_mant("mant_out", mant_out, m_want);
		check_flags("flags", flags, f_want);
	endtask

	task automatic run_op(input fop_t o, input exp_t ei, input exp_t er, input mant_t mi);
		pulse_start(o, ei, er, mi);
		wait_for_done();
		check_result(o, ei, er, mi);
	endtask

`endif

//--- verification/fpm_tb.sv
// fpm testbench
// directed and LFSR-driven tests of the mantissa alignment and
// normalization unit against a behavioral reference model

`timescale 1ns/1ps
`default_nettype none

module fpm_tb;

	import fpm_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int NUM_OPS = 45;
	// longest operation is 42 cycles plus the start pulse
	localparam int TIMEOUT_CYCLES = NUM_OPS * 50 + RESET_CYCLES + 20;
	localparam int DONE_WAIT = 48;
	localparam int MSB = $bits(mant_t) - 1;
	localparam exp_t EXP_FLOOR = exp_t'(8'h80);

	logic f2strob;
	logic M55_6;
	logic start;
	fop_t op;
	exp_t exp_in;
	exp_t exp_ref;
	mant_t mant_in;
	logic busy;
	logic done;
	exp_t exp_out;
	mant_t mant_out;
	fpm_flags_t flags;

	int errors = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int done_cnt = 0;
	int cycle_cnt = 0;
	string cur_test = "";
	logic [31:0] lfsr = 32'h886f577d;

	`include "fpm_tb_tasks.svh"

	fpm_top #(
		.n_slice(NSLICE)
	) i_fpm_top (
		.f2strob(f2strob),
		.M55_6(M55_6),
		.start(start),
		.op(op),
		.exp_in(exp_in),
		.exp_ref(exp_ref),
		.mant_in(mant_in),
		.busy(busy),
		.done(done),
		.exp_out(exp_out),
		.mant_out(mant_out),
		.flags(flags)
	);

	initial begin
		f2strob = 1'b0;
		forever #10 f2strob = ~f2strob;
	end

	always @(negedge f2strob) begin
		if (done) begin
			done_cnt++;
		end
	end

	always @(posedge f2strob) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout: run went past %0d cycles in test %s", TIMEOUT_CYCLES, cur_test);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic open_test(input string name);
		cur_test = name;
		test_start_errors = errors;
	endtask

	task automatic close_test();
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_start_errors);
		end
	endtask

	// reset state, single done pulse, start while busy
	task automatic test_protocol();
		int base;
		open_test("protocol");
		@(negedge f2strob);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_exp("exp_out", exp_out, 8'sd0);
		check_mant("mant_out", mant_out, '0);
		check_flags("flags", flags, '0);
		base = done_cnt;
		pulse_start(FOP_ALIGN, -8'sd20, 8'sd10, 40'h9A_5C3E_71F0);
		repeat (3) @(posedge f2strob);
		pulse_start(FOP_NORM, 8'sd3, 8'sd0, 40'h00_0000_00FF);
		wait_for_done();
		check_result(FOP_ALIGN, -8'sd20, 8'sd10, 40'h9A_5C3E_71F0);
		check_bit("busy", busy, 1'b1);
		@(negedge f2strob);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		repeat (4) @(negedge f2strob);
		check_result(FOP_ALIGN, -8'sd20, 8'sd10, 40'h9A_5C3E_71F0);
		if (done_cnt - base != 1) begin
			errors++;
			$display("done pulsed %0d times for one accepted start", done_cnt - base);
		end
		close_test();
	endtask

	task automatic test_norm_unnorm();
		open_test("normalize unnormalized");
		run_op(FOP_NORM, 8'sd10, 8'sd0, 40'h00_1234_5678);
		run_op(FOP_NORM, 8'sd0, 8'sd0, 40'hFF_F000_0000);
		run_op(FOP_NORM, -8'sd5, 8'sd0, 40'h40_0000_0000);
		run_op(FOP_NORM, 8'sd100, 8'sd0, 40'h00_0000_0001);
		run_op(FOP_NORM, 8'sd20, 8'sd0, 40'hFF_FFFF_FFFE);
		close_test();
	endtask

	task automatic test_norm_zero_underflow();
		open_test("normalize zero and underflow");
		run_op(FOP_NORM, 8'sd5, 8'sd0, 40'h00_0000_0000);
		run_op(FOP_NORM, EXP_FLOOR, 8'sd0, 40'h00_0000_0000);
		run_op(FOP_NORM, -8'sd120, 8'sd0, 40'h00_0000_0001);
		run_op(FOP_NORM, EXP_FLOOR, 8'sd0, 40'h00_0100_0000);
		run_op(FOP_NORM, EXP_FLOOR, 8'sd0, 40'hBF_FFFF_FFFF);
		close_test();
	endtask

	task automatic test_align_small();
		open_test("align 0 to 39");
		run_op(FOP_ALIGN, 8'sd5, 8'sd5, 40'h12_3456_789A);
		run_op(FOP_ALIGN, 8'sd4, 8'sd5, 40'h80_0000_0001);
		run_op(FOP_ALIGN, -8'sd3, 8'sd4, 40'h7F_FFFF_FF80);
		run_op(FOP_ALIGN, 8'sd0, 8'sd8, 40'hC3_0000_0100);
		run_op(FOP_ALIGN, -8'sd10, 8'sd7, 40'hF0_0F0F_0F0F);
		run_op(FOP_ALIGN, -8'sd30, 8'sd9, 40'h40_0000_0000);
		close_test();
	endtask

	task automatic test_align_large_neg();
		open_test("align large and negative");
		run_op(FOP_ALIGN, 8'sd0, 8'sd40, 40'h00_0000_0001);
		run_op(FOP_ALIGN, -8'sd100, 8'sd100, 40'hA5_0000_0000);
		run_op(FOP_ALIGN, 8'sd10, 8'sd60, 40'h00_0000_0000);
		run_op(FOP_ALIGN, 8'sd5, -8'sd3, 40'h12_3456_789A);
		run_op(FOP_ALIGN, 8'sd127, EXP_FLOOR, 40'hFF_0000_0000);
		close_test();
	endtask

	task automatic test_random();
		mant_t r;
		mant_t m;
		fop_t o;
		exp_t ei;
		exp_t er;
		open_test("random mix");
		for (int k = 0; k < 20; k++) begin
			r = take_bits(1);
			o = r[0] ? FOP_ALIGN : FOP_NORM;
			m = take_bits(40);
			r = take_bits(5);
			// leading sign copies so normalize has work to do
			m = mant_t'($signed(m) >>> r[4:0]);
			r = take_bits(8);
			er = exp_t'(r[7:0]);
			r = take_bits(6);
			ei = er - exp_t'(r[5:0]) + 8'sd4;
			run_op(o, ei, er, m);
		end
		close_test();
	endtask

	initial begin
		M55_6 = 1'b0;
		start = 1'b0;
		op = FOP_NORM;
		exp_in = '0;
		exp_ref = '0;
		mant_in = '0;
		repeat (RESET_CYCLES) @(posedge f2strob);
		#2;
		M55_6 = 1'b1;
		test_protocol();
		test_norm_unnorm();
		test_norm_zero_underflow();
		test_align_small();
		test_align_large_neg();
		test_random();
		$display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
rtl/fpm_pkg.sv
rtl/fpm_slice.sv
rtl/fpm_seq.sv
rtl/fpm_collect.sv
rtl/fpm_top.sv
verification/fpm_tb.sv

//--- run.sh
#!/bin/sh
# build the fpm testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module fpm_tb -o fpm_sim || exit 1
out=$(./obj_dir/fpm_sim)
echo "$out"
echo "$out" | grep -q "PASS: all tests" && exit 0 || exit 1
